/* src/audio_pkg.sv */
package audio_pkg;

  // cpu i/o port map, 8-bit port addresses
  // pan register, read and write
  localparam logic [7:0] port_mixer    = 8'hF7;
  // drum sample latch, write only
  localparam logic [7:0] port_drum     = 8'hDF;
  // psg register select, read returns the selected register
  localparam logic [7:0] port_psg_sel  = 8'hFD;
  // psg data write
  localparam logic [7:0] port_psg_data = 8'hBF;

  // pattern seen on the data bus when nobody answers
  localparam logic [7:0] bus_idle_data = 8'hFF;

  // every channel on both speakers after reset
  localparam logic [7:0] mixer_reset_value = 8'hFF;

  // mix sums and dac levels
  localparam int mix_width = 11;
  localparam int dac_width = 9;

  // clock cycles per psg tone counter tick
  localparam int psg_prescale = 16;

  // beeper level, indexed by {ear, spk, mic}
  localparam logic [7:0] beeper_levels [8] = '{
    8'd0, 8'd36, 8'd184, 8'd192, 8'd64, 8'd100, 8'd248, 8'd255
  };

  // roughly logarithmic psg volume curve, volume 0 is silent
  localparam logic [7:0] psg_volume_levels [16] = '{
    8'd0,   8'd2,   8'd3,   8'd4,   8'd6,   8'd8,   8'd11,  8'd16,
    8'd23,  8'd32,  8'd45,  8'd64,  8'd90,  8'd128, 8'd180, 8'd255
  };

  // pan register, seen as a raw byte by the bus
  // or as four pan fields by the mixer
  // in each field bit 1 is left and bit 0 is right
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [1:0] a;
      logic [1:0] b;
      logic [1:0] c;
      // beeper and drum group
      logic [1:0] d;
    } pan;
  } mixer_reg_u;

endpackage

/* src/io_read_arbiter.sv */
`timescale 1ns/1ps

module io_read_arbiter import audio_pkg::*; (
  input  logic       mixer_oe,
  input  logic [7:0] mixer_dout,
  input  logic       psg_oe,
  input  logic [7:0] psg_dout,
  output logic [7:0] dout,
  output logic       oe
);

  // fixed priority, mixer first, then psg
  // each peer only knows its own ports, so the order lives here
  always_comb begin
    if (mixer_oe) begin
      dout = mixer_dout;
    end else if (psg_oe) begin
      dout = psg_dout;
    end else begin
      // nobody answers, bus floats high
      dout = bus_idle_data;
    end
  end

  // cpu sees a driven bus whenever any peer answers
  assign oe = mixer_oe | psg_oe;

endmodule

/* src/tone_psg.sv */
`timescale 1ns/1ps

module tone_psg import audio_pkg::*; (
  input  logic       clk,
  input  logic       mrst_n,
  input  logic [7:0] a,
  input  logic [7:0] din,
  input  logic       iorq_n,
  input  logic       rd_n,
  input  logic       wr_n,
  output logic [7:0] dout,
  output logic       oe,
  output logic [7:0] cha,
  output logic [7:0] chb,
  output logic [7:0] chc
);

  // register select latch, only the low nibble is kept
  logic [3:0]  reg_sel;
  // registers 0..5, tone periods as fine and coarse pairs
  logic [7:0]  period_fine [3];
  logic [3:0]  period_coarse [3];
  // register 7, tone disable per channel, bit 0 is A
  logic [2:0]  tone_dis;
  // registers 8..10
  logic [3:0]  volume [3];

  logic [11:0] period_eff [3];
  logic [11:0] tone_cnt [3];
  logic [2:0]  square;
  logic [7:0]  ch_level [3];
  logic [$clog2(psg_prescale)-1:0] prescale_cnt;
  logic        tick;
  logic        sel_wr;
  logic        data_wr;

  // bus decode
  assign sel_wr  = !iorq_n && !wr_n && (a == port_psg_sel);
  assign data_wr = !iorq_n && !wr_n && (a == port_psg_data);
  assign oe      = !iorq_n && !rd_n && (a == port_psg_sel);

  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      reg_sel  <= '0;
      tone_dis <= '0;
      for (int i = 0; i < 3; i++) begin
        period_fine[i]   <= '0;
        period_coarse[i] <= '0;
        volume[i]        <= '0;
      end
    end else begin
      if (sel_wr) begin
        reg_sel <= din[3:0];
      end
      if (data_wr) begin
        // pairs 0/1, 2/3, 4/5 map to channel reg_sel[2:1]
        case (reg_sel)
          4'd0, 4'd2, 4'd4: period_fine[reg_sel[2:1]] <= din;
          4'd1, 4'd3, 4'd5: period_coarse[reg_sel[2:1]] <= din[3:0];
          4'd7: tone_dis <= din[2:0];
          // 8, 9, 10 land on channels 0, 1, 2
          4'd8, 4'd9, 4'd10: volume[reg_sel[1:0]] <= din[3:0];
          // noise and envelope registers are not implemented
          default: ;
        endcase
      end
    end
  end

  // readback of the selected register, unused bits read as zero
  always_comb begin
    case (reg_sel)
      4'd0, 4'd2, 4'd4: dout = period_fine[reg_sel[2:1]];
      4'd1, 4'd3, 4'd5: dout = {4'h0, period_coarse[reg_sel[2:1]]};
      4'd7: dout = {5'b0_0000, tone_dis};
      4'd8, 4'd9, 4'd10: dout = {4'h0, volume[reg_sel[1:0]]};
      default: dout = 8'h00;
    endcase
  end

  // 12-bit periods, a period of 0 behaves like 1
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      period_eff[i] = {period_coarse[i], period_fine[i]};
      if (period_eff[i] == 12'd0) begin
        period_eff[i] = 12'd1;
      end
    end
  end

  // one tick every psg_prescale clocks
  assign tick = (prescale_cnt == $bits(prescale_cnt)'(psg_prescale - 1));

  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      prescale_cnt <= '0;
      square       <= '0;
      for (int i = 0; i < 3; i++) begin
        tone_cnt[i] <= '0;
        ch_level[i] <= '0;
      end
    end else begin
      prescale_cnt <= tick ? '0 : prescale_cnt + 1'b1;
      for (int i = 0; i < 3; i++) begin
        if (tick) begin
          // count up to the period, then flip the square bit
          // >= so a shortened period wraps at once
          if (tone_cnt[i] >= period_eff[i]) begin
            tone_cnt[i] <= '0;
            square[i]   <= !square[i];
          end else begin
            tone_cnt[i] <= tone_cnt[i] + 12'd1;
          end
        end
        // disabled tone holds the channel at its volume level
        if (square[i] || tone_dis[i]) begin
          ch_level[i] <= psg_volume_levels[volume[i]];
        end else begin
          ch_level[i] <= 8'd0;
        end
      end
    end
  end

  assign cha = ch_level[0];
  assign chb = ch_level[1];
  assign chc = ch_level[2];

endmodule

/* src/pan_mixer.sv */
`timescale 1ns/1ps

module pan_mixer import audio_pkg::*; (
  input  logic                 clk,
  input  logic                 mrst_n,
  input  logic [7:0]           a,
  input  logic [7:0]           din,
  input  logic                 iorq_n,
  input  logic                 rd_n,
  input  logic                 wr_n,
  output logic [7:0]           dout,
  output logic                 oe,
  input  logic                 ear,
  input  logic                 spk,
  input  logic                 mic,
  input  logic [7:0]           cha,
  input  logic [7:0]           chb,
  input  logic [7:0]           chc,
  output logic [dac_width-1:0] left_level,
  output logic [dac_width-1:0] right_level
);

  mixer_reg_u           pan_reg;
  logic [7:0]           drum;
  logic                 pan_wr;
  logic                 drum_wr;

  // widened sources of stage 1
  logic [mix_width-1:0] cha_w;
  logic [mix_width-1:0] chb_w;
  logic [mix_width-1:0] chc_w;
  logic [mix_width-1:0] beep_w;
  logic [mix_width-1:0] drum_w;

  // per side sums of stage 2
  logic [mix_width-1:0] sum_left;
  logic [mix_width-1:0] sum_right;

  // bus decode
  assign pan_wr  = !iorq_n && !wr_n && (a == port_mixer);
  assign drum_wr = !iorq_n && !wr_n && (a == port_drum);

  // only the pan register is readable
  assign dout = pan_reg.raw;
  assign oe   = !iorq_n && !rd_n && (a == port_mixer);

  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      pan_reg.raw <= mixer_reset_value;
      drum        <= 8'h00;
    end else begin
      if (pan_wr) begin
        pan_reg.raw <= din;
      end
      if (drum_wr) begin
        drum <= din;
      end
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      beep_w <= '0;
      cha_w  <= '0;
      chb_w  <= '0;
      chc_w  <= '0;
      drum_w <= '0;
    end else begin
      // beeper lookup from the three one-bit sources
      beep_w <= {{(mix_width-8){1'b0}}, beeper_levels[{ear, spk, mic}]};
      // tone channels zero-extended
      cha_w  <= {{(mix_width-8){1'b0}}, cha};
      chb_w  <= {{(mix_width-8){1'b0}}, chb};
      chc_w  <= {{(mix_width-8){1'b0}}, chc};
      // drum byte scaled by two with its top bit in the lsb
      drum_w <= {{(mix_width-9){1'b0}}, drum, drum[7]};
    end
  end

  // stage 2
  // bit 1 of each pan field gates the left sum, bit 0 the right
  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      sum_left  <= '0;
      sum_right <= '0;
    end else begin
      sum_left  <= (pan_reg.pan.a[1] ? cha_w : '0) +
                   (pan_reg.pan.b[1] ? chb_w : '0) +
                   (pan_reg.pan.c[1] ? chc_w : '0) +
                   (pan_reg.pan.d[1] ? beep_w + drum_w : '0);
      sum_right <= (pan_reg.pan.a[0] ? cha_w : '0) +
                   (pan_reg.pan.b[0] ? chb_w : '0) +
                   (pan_reg.pan.c[0] ? chc_w : '0) +
                   (pan_reg.pan.d[0] ? beep_w + drum_w : '0);
    end
  end

  // stage 3 keeps the upper bits
  // full scale of all sources stays below 2048
  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      left_level  <= '0;
      right_level <= '0;
    end else begin
      left_level  <= sum_left[mix_width-1 -: dac_width];
      right_level <= sum_right[mix_width-1 -: dac_width];
    end
  end

endmodule

/* src/sigma_delta_dac.sv */
`timescale 1ns/1ps

module sigma_delta_dac import audio_pkg::*; (
  input  logic                 clk,
  input  logic                 mrst_n,
  input  logic [dac_width-1:0] level,
  output logic                 out_bit
);

  // integrator, two bits wider than the level
  logic [dac_width+1:0] sigma;
  // feedback, top bit copied into the two upper positions
  logic [dac_width+1:0] delta;

  assign delta = {sigma[dac_width+1], sigma[dac_width+1], {dac_width{1'b0}}};

  always_ff @(posedge clk) begin
    if (!mrst_n) begin
      // start at mid scale
      sigma   <= {2'b01, {dac_width{1'b0}}};
      out_bit <= 1'b0;
    end else begin
      sigma   <= sigma + delta + {2'b00, level};
      // registered output keeps the pin glitch free
      out_bit <= sigma[dac_width+1];
    end
  end

endmodule

/* src/audio_top.sv */
`timescale 1ns/1ps

module audio_top import audio_pkg::*; (
  input  logic       clk,
  input  logic       mrst_n,
  input  logic [7:0] a,
  input  logic [7:0] din,
  input  logic       iorq_n,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic       ear,
  input  logic       spk,
  input  logic       mic,
  output logic [7:0] dout,
  output logic       oe,
  output logic       output_left,
  output logic       output_right
);

  logic [7:0]           psg_dout;
  logic                 psg_oe;
  logic [7:0]           mixer_dout;
  logic                 mixer_oe;
  logic [7:0]           cha;
  logic [7:0]           chb;
  logic [7:0]           chc;
  logic [dac_width-1:0] left_level;
  logic [dac_width-1:0] right_level;

  // three-channel tone source
  tone_psg psg0 (
    .clk    (clk),
    .mrst_n (mrst_n),
    .a      (a),
    .din    (din),
    .iorq_n (iorq_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .dout   (psg_dout),
    .oe     (psg_oe),
    .cha    (cha),
    .chb    (chb),
    .chc    (chc)
  );

  // pan register, drum latch and the mix pipeline
  pan_mixer mix0 (
    .clk         (clk),
    .mrst_n      (mrst_n),
    .a           (a),
    .din         (din),
    .iorq_n      (iorq_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .dout        (mixer_dout),
    .oe          (mixer_oe),
    .ear         (ear),
    .spk         (spk),
    .mic         (mic),
    .cha         (cha),
    .chb         (chb),
    .chc         (chc),
    .left_level  (left_level),
    .right_level (right_level)
  );

  // one read data bus for both peers
  io_read_arbiter arb0 (
    .mixer_oe   (mixer_oe),
    .mixer_dout (mixer_dout),
    .psg_oe     (psg_oe),
    .psg_dout   (psg_dout),
    .dout       (dout),
    .oe         (oe)
  );

  sigma_delta_dac dac_left (
    .clk     (clk),
    .mrst_n  (mrst_n),
    .level   (left_level),
    .out_bit (output_left)
  );

  sigma_delta_dac dac_right (
    .clk     (clk),
    .mrst_n  (mrst_n),
    .level   (right_level),
    .out_bit (output_right)
  );

endmodule

/* testbench/audio_tb.sv */
`timescale 1ns/1ps

module audio_tb import audio_pkg::*; ();

  localparam int clk_period  = 8;
  // average cycle budget of each of the six tests
  localparam int test_cycles = 4000;
  localparam int test_total  = 6;

  logic       clk;
  logic       mrst_n;
  logic [7:0] a;
  logic [7:0] din;
  logic       iorq_n;
  logic       rd_n;
  logic       wr_n;
  logic       ear;
  logic       spk;
  logic       mic;
  logic [7:0] bus_dout;
  logic       bus_oe;
  logic       output_left;
  logic       output_right;

  int          error_count = 0;
  int          check_count = 0;
  logic [15:0] lfsr_state  = 16'd53592;

  audio_top dut0 (
    .clk          (clk),
    .mrst_n       (mrst_n),
    .a            (a),
    .din          (din),
    .iorq_n       (iorq_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .ear          (ear),
    .spk          (spk),
    .mic          (mic),
    .dout         (bus_dout),
    .oe           (bus_oe),
    .output_left  (output_left),
    .output_right (output_right)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // watchdog ends the run after the budget of all six tests
  initial begin
    #(test_total * test_cycles * clk_period);
    $display("Error: watchdog expired before all tests finished");
    $display("checks: %0d, errors: %0d", check_count, error_count + 1);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_equal(input string name, input int expected, input int actual);
    check_count++;
    assert (actual == expected) else begin
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_within(input string name, input int expected, input int actual,
                              input int tol);
    check_count++;
    assert (actual >= expected - tol && actual <= expected + tol) else begin
      $display("Fail %s: expected %0d +/- %0d, actual %0d", name, expected, tol, actual);
      error_count++;
    end
  endtask

  // taps for x^16 + x^14 + x^13 + x^11 + 1
  // the new bit shifts in at the bottom
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  // enabled sources are summed per side
  // group d carries the beeper level plus the drum term
  // the drum byte widens to twice its value plus its top bit
  // the level keeps the sum over 4
  function automatic int expected_level(input mixer_reg_u pan_reg, input logic left,
                                        input logic [7:0] la, input logic [7:0] lb,
                                        input logic [7:0] lc, input logic [2:0] beep_idx,
                                        input logic [7:0] drum);
    int sum;
    int group_d;
    group_d = int'(beeper_levels[beep_idx]) + 2 * int'(drum) + int'(drum[7]);
    sum = 0;
    if (left ? pan_reg.pan.a[1] : pan_reg.pan.a[0]) sum += int'(la);
    if (left ? pan_reg.pan.b[1] : pan_reg.pan.b[0]) sum += int'(lb);
    if (left ? pan_reg.pan.c[1] : pan_reg.pan.c[0]) sum += int'(lc);
    if (left ? pan_reg.pan.d[1] : pan_reg.pan.d[0]) sum += group_d;
    return sum / 4;
  endfunction

  // write is taken on the second rising edge
  task automatic io_write(input logic [7:0] port, input logic [7:0] data);
    @(posedge clk);
    a      <= port;
    din    <= data;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    @(posedge clk);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
  endtask

  // read data is combinational and sampled mid cycle
  task automatic io_read(input logic [7:0] port, output logic [7:0] data, output logic en);
    @(posedge clk);
    a      <= port;
    iorq_n <= 1'b0;
    rd_n   <= 1'b0;
    @(negedge clk);
    data = bus_dout;
    en   = bus_oe;
    @(posedge clk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
  endtask

  task automatic psg_write(input logic [3:0] r, input logic [7:0] v);
    io_write(port_psg_sel, {4'h0, r});
    io_write(port_psg_data, v);
  endtask

  task automatic clear_psg();
    for (int r = 0; r < 11; r++) begin
      psg_write(4'(r), 8'h00);
    end
  endtask

  // bits that a psg register keeps
  function automatic logic [7:0] psg_readback_mask(input int r);
    case (r)
      0, 2, 4: return 8'hFF;
      1, 3, 5: return 8'h0F;
      7: return 8'h07;
      8, 9, 10: return 8'h0F;
      default: return 8'h00;
    endcase
  endfunction

  // settle, then count ones over a 512 cycle window
  task automatic measure_density(output int ones_left, output int ones_right);
    ones_left  = 0;
    ones_right = 0;
    repeat (8) @(posedge clk);
    repeat (512) begin
      @(negedge clk);
      ones_left  += int'(output_left);
      ones_right += int'(output_right);
    end
  endtask

  task automatic measure_and_compare(input string name, input logic [7:0] pan_raw,
                                     input logic [7:0] la, input logic [7:0] lb,
                                     input logic [7:0] lc, input logic [2:0] beep_idx,
                                     input logic [7:0] drum);
    mixer_reg_u pan_reg;
    int ones_left;
    int ones_right;
    pan_reg.raw = pan_raw;
    measure_density(ones_left, ones_right);
    check_within({name, " left"},
                 expected_level(pan_reg, 1'b1, la, lb, lc, beep_idx, drum), ones_left, 1);
    check_within({name, " right"},
                 expected_level(pan_reg, 1'b0, la, lb, lc, beep_idx, drum), ones_right, 1);
  endtask

  task automatic reset_and_idle_bus();
    logic [7:0] d;
    logic       o;
    @(negedge clk);
    check_equal("reset output_left", 0, int'(output_left));
    check_equal("reset output_right", 0, int'(output_right));
    check_equal("reset idle oe", 0, int'(bus_oe));
    io_read(port_mixer, d, o);
    check_equal("reset pan data", int'(mixer_reset_value), int'(d));
    check_equal("reset pan oe", 1, int'(o));
    // unmapped and write-only ports leave the bus idle
    io_read(8'h00, d, o);
    check_equal("unmapped oe", 0, int'(o));
    check_equal("unmapped data", int'(bus_idle_data), int'(d));
    io_read(port_drum, d, o);
    check_equal("drum read oe", 0, int'(o));
  endtask

  task automatic register_readback();
    logic [7:0] b;
    logic [7:0] d;
    logic       o;
    logic [7:0] written [11];
    for (int i = 0; i < 16; i++) begin
      random_byte(b);
      io_write(port_mixer, b);
      io_read(port_mixer, d, o);
      check_equal($sformatf("pan readback %0d", i), int'(b), int'(d));
    end
    for (int r = 0; r < 11; r++) begin
      random_byte(written[r]);
      psg_write(4'(r), written[r]);
    end
    for (int r = 0; r < 11; r++) begin
      io_write(port_psg_sel, 8'(r));
      io_read(port_psg_sel, d, o);
      check_equal($sformatf("psg reg %0d oe", r), 1, int'(o));
      check_equal($sformatf("psg reg %0d", r), int'(written[r] & psg_readback_mask(r)),
                  int'(d));
    end
  endtask

  task automatic beeper_table();
    io_write(port_mixer, 8'hFF);
    io_write(port_drum, 8'h00);
    clear_psg();
    for (int idx = 0; idx < 8; idx++) begin
      @(posedge clk);
      ear <= idx[2];
      spk <= idx[1];
      mic <= idx[0];
      measure_and_compare($sformatf("beeper %0d", idx), 8'hFF, 8'h00, 8'h00, 8'h00,
                          3'(idx), 8'h00);
    end
  endtask

  task automatic panning();
    // left only, right only, both, mute on group a
    logic [7:0] pan_set [4] = '{8'h80, 8'h40, 8'hC0, 8'h00};
    @(posedge clk);
    ear <= 1'b0;
    spk <= 1'b0;
    mic <= 1'b0;
    clear_psg();
    psg_write(4'd7, 8'h01);
    psg_write(4'd8, 8'h0F);
    for (int i = 0; i < 4; i++) begin
      io_write(port_mixer, pan_set[i]);
      measure_and_compare($sformatf("pan %02h", pan_set[i]), pan_set[i],
                          psg_volume_levels[15], 8'h00, 8'h00, 3'd0, 8'h00);
    end
  endtask

  task automatic drum_port();
    logic [7:0] b;
    clear_psg();
    io_write(port_mixer, 8'h03);
    for (int i = 0; i < 6; i++) begin
      random_byte(b);
      io_write(port_drum, b);
      measure_and_compare($sformatf("drum %02h", b), 8'h03, 8'h00, 8'h00, 8'h00, 3'd0, b);
    end
  endtask

  task automatic tone_square_wave();
    mixer_reg_u pan_reg;
    int ones_left;
    int ones_right;
    int half;
    pan_reg.raw = 8'h30;
    // half the level that a steady channel b would give
    half = expected_level(pan_reg, 1'b1, 8'h00, psg_volume_levels[15], 8'h00, 3'd0,
                          8'h00) / 2;
    io_write(port_drum, 8'h00);
    clear_psg();
    io_write(port_mixer, pan_reg.raw);
    psg_write(4'd2, 8'h01);
    psg_write(4'd9, 8'h0F);
    // let the tone counter settle into its period of four prescaler ticks
    repeat (4 * psg_prescale) @(posedge clk);
    measure_density(ones_left, ones_right);
    check_within("tone b left", half, ones_left, 4);
    check_within("tone b right", half, ones_right, 4);
  endtask

  initial begin
    mrst_n = 1'b0;
    a      = 8'h00;
    din    = 8'h00;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    ear    = 1'b0;
    spk    = 1'b0;
    mic    = 1'b0;
    repeat (3) @(posedge clk);
    mrst_n <= 1'b1;
    reset_and_idle_bus();
    register_readback();
    beeper_table();
    panning();
    drum_port();
    tone_square_wave();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/audio_pkg.sv
src/io_read_arbiter.sv
src/tone_psg.sv
src/pan_mixer.sv
src/sigma_delta_dac.sv
src/audio_top.sv
testbench/audio_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the audio testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module audio_tb -f vlog.f -o audio_sim
./obj_dir/audio_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished, no failure in sim.log"
